// ==== common/vlu_pkg.sv ====
/*
 * Vector logic unit package
 * Widths, register map, operand types and command encoding
 */
`default_nettype none

package vlu_pkg;

    localparam int DATA_WIDTH    = 64;
    localparam int BYTE_WIDTH    = 8;
    localparam int NUM_BYTES     = DATA_WIDTH / BYTE_WIDTH;
    localparam int NUM_SIZES     = 4;
    localparam int VL_WIDTH      = 7;
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 4;

    typedef logic [DATA_WIDTH-1:0]    vlu_data_t;
    typedef logic [NUM_BYTES-1:0]     vlu_byte_valid_t;
    typedef logic [VL_WIDTH-1:0]      vlu_vl_t;
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

    // Word addresses
    localparam wb_addr_t ADDR_SRCA_LO   = 4'd0;
    localparam wb_addr_t ADDR_SRCA_HI   = 4'd1;
    localparam wb_addr_t ADDR_SRCB_LO   = 4'd2;
    localparam wb_addr_t ADDR_SRCB_HI   = 4'd3;
    localparam wb_addr_t ADDR_CMD       = 4'd4;
    localparam wb_addr_t ADDR_STATUS    = 4'd5;
    localparam wb_addr_t ADDR_RESULT_LO = 4'd6;
    localparam wb_addr_t ADDR_RESULT_HI = 4'd7;
    localparam wb_addr_t ADDR_VALID     = 4'd8;

    typedef enum logic [1:0] {
        OSIZE_8, OSIZE_16, OSIZE_32, OSIZE_64
    } vlu_osize_e;

    typedef enum logic [2:0] {
        OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA
    } vlu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE, ST_EXEC, ST_ACK
    } vlu_ctrl_state_e;

    // Low bits of a CMD write, vl in the lowest bits
    typedef struct packed {
        vlu_op_e    op;
        vlu_osize_e osize;
        logic       negate_srca;
        logic       negate_result;
        logic       is_mask;
        logic       is_reduct;
        vlu_vl_t    vl;
    } vlu_cmd_t;

    localparam int CMD_WIDTH = $bits(vlu_cmd_t);

    typedef struct packed {
        vlu_data_t       data;
        vlu_byte_valid_t valid;
    } vlu_result_t;

endpackage

`default_nettype wire

// ==== vector_alu/vector_shifter.sv ====
/*
 * Vector shifter
 * Per-element SLL, SRL and SRA at 8, 16, 32 and 64 bit elements
 */
`timescale 1ns/1ps
`default_nettype none

module vector_shifter
    import vlu_pkg::*;
(
    input  vlu_data_t  srca,
    input  vlu_data_t  srcb,
    input  vlu_op_e    op,
    input  vlu_osize_e osize,
    output vlu_data_t  result
);
    logic [NUM_SIZES-1:0][DATA_WIDTH-1:0] size_result;

    // Every element size is computed, osize picks one
    for (genvar s = 0; s < NUM_SIZES; s++) begin : g_size
        localparam int W = BYTE_WIDTH << s;

        for (genvar e = 0; e < DATA_WIDTH / W; e++) begin : g_elem
            logic [W-1:0]         a;
            logic [$clog2(W)-1:0] amt;

            assign a   = srca[e*W +: W];
            // Only log2(W) bits of the amount count
            assign amt = srcb[e*W +: $clog2(W)];

            assign size_result[s][e*W +: W] =
                (op == OP_SLL) ? (a << amt) :
                (op == OP_SRL) ? (a >> amt) :
                (op == OP_SRA) ? W'($signed(a) >>> amt) : '0;
        end
    end

    assign result = size_result[osize];

    always_comb begin
        a_op_legal: assert final ($isunknown(op) ||
            op inside {OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA});
    end

endmodule

`default_nettype wire

// ==== vector_alu/vector_reducer.sv ====
/*
 * Vector reducer
 * AND, OR or XOR fold of active source A elements into element 0
 */
`timescale 1ns/1ps
`default_nettype none

module vector_reducer
    import vlu_pkg::*;
(
    input  vlu_data_t  srca,
    input  vlu_data_t  srcb,
    input  vlu_op_e    op,
    input  vlu_osize_e osize,
    input  vlu_vl_t    vl,
    output vlu_data_t  result
);
    logic [NUM_SIZES-1:0][DATA_WIDTH-1:0] size_result;

    for (genvar s = 0; s < NUM_SIZES; s++) begin : g_size
        localparam int W = BYTE_WIDTH << s;
        localparam int N = DATA_WIDTH / W;

        logic [W-1:0] acc;

        // Seed with element 0 of source B
        always_comb begin
            acc = srcb[W-1:0];
            for (int e = 0; e < N; e++) begin
                if (vlu_vl_t'(e) < vl) begin
                    case (op)
                        OP_AND:  acc = acc & srca[e*W +: W];
                        OP_OR:   acc = acc | srca[e*W +: W];
                        OP_XOR:  acc = acc ^ srca[e*W +: W];
                        default: acc = acc;
                    endcase
                end
            end
        end

        assign size_result[s] = vlu_data_t'(acc);
    end

    assign result = size_result[osize];

endmodule

`default_nettype wire

// ==== vector_alu/vector_logic_alu.sv ====
/*
 * Vector logical ALU
 * Bitwise ops with negation, shift and reduction merge, tail clearing
 */
`timescale 1ns/1ps
`default_nettype none

module vector_logic_alu
    import vlu_pkg::*;
(
    input  vlu_data_t   srca,
    input  vlu_data_t   srcb,
    input  vlu_cmd_t    cmd,
    output vlu_result_t result
);
    logic            is_shift;
    logic            eff_mask;
    logic            eff_reduct;
    vlu_osize_e      eff_osize;
    logic [1:0]      size_shift;
    vlu_data_t       srca_bw;
    vlu_data_t       bw_pre;
    vlu_data_t       negate_bits;
    vlu_data_t       shift_result;
    vlu_data_t       reduct_result;
    vlu_data_t       sel_result;
    vlu_data_t       bit_keep;
    vlu_data_t       byte_keep;
    vlu_byte_valid_t byte_active;
    vlu_byte_valid_t elem0_bytes;
    vlu_byte_valid_t valid;

    assign is_shift   = cmd.op inside {OP_SLL, OP_SRL, OP_SRA};
    // Shifts ignore reduction; in mask mode they run on bytes
    assign eff_mask   = cmd.is_mask && !is_shift;
    assign eff_reduct = cmd.is_reduct && !cmd.is_mask && !is_shift;
    assign eff_osize  = (cmd.is_mask && is_shift) ? OSIZE_8 : cmd.osize;
    assign size_shift = eff_osize;

    assign srca_bw     = srca ^ {DATA_WIDTH{cmd.negate_srca}};
    assign negate_bits = {DATA_WIDTH{cmd.negate_result}};

    always_comb begin
        case (cmd.op)
            OP_AND:  bw_pre = srca_bw & srcb;
            OP_OR:   bw_pre = srca_bw | srcb;
            OP_XOR:  bw_pre = srca_bw ^ srcb;
            default: bw_pre = '0;
        endcase
    end

    vector_shifter shifter (
        .srca   (srca),
        .srcb   (srcb),
        .op     (cmd.op),
        .osize  (eff_osize),
        .result (shift_result)
    );

    vector_reducer reducer (
        .srca   (srca_bw),
        .srcb   (srcb),
        .op     (cmd.op),
        .osize  (cmd.osize),
        .vl     (cmd.vl),
        .result (reduct_result)
    );

    always_comb begin
        if (is_shift) begin
            sel_result = shift_result;
        end else if (eff_reduct) begin
            sel_result = reduct_result ^ negate_bits;
        end else begin
            sel_result = bw_pre ^ negate_bits;
        end
    end

    // Element index of a byte is its index shifted by log2 of the element bytes
    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            byte_active[b] = vlu_vl_t'(b >> size_shift) < cmd.vl;
            elem0_bytes[b] = (b >> size_shift) == 0;
        end
        for (int i = 0; i < DATA_WIDTH; i++) begin
            bit_keep[i] = vlu_vl_t'(i) < cmd.vl;
        end
    end

    always_comb begin
        if (eff_mask) begin
            valid = '1;
        end else if (eff_reduct) begin
            valid = byte_active & elem0_bytes;
        end else begin
            valid = byte_active;
        end
        for (int b = 0; b < NUM_BYTES; b++) begin
            byte_keep[b*BYTE_WIDTH +: BYTE_WIDTH] = {BYTE_WIDTH{valid[b]}};
        end
    end

    assign result.data  = sel_result & (eff_mask ? bit_keep : byte_keep);
    assign result.valid = valid;

endmodule

`default_nettype wire

// ==== logic/vlu_operand_regs.sv ====
/*
 * Vector logic unit registers
 * Operands built from 32-bit halves, command word and captured result
 */
`timescale 1ns/1ps
`default_nettype none

module vlu_operand_regs
    import vlu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  wb_data_t    dat_w,
    input  logic        srca_lo_we,
    input  logic        srca_hi_we,
    input  logic        srcb_lo_we,
    input  logic        srcb_hi_we,
    input  logic        cmd_we,
    input  logic        result_we,
    input  vlu_result_t alu_result,
    output vlu_data_t   srca,
    output vlu_data_t   srcb,
    output vlu_cmd_t    cmd,
    output vlu_result_t result
);

    always_ff @(posedge clk) begin
        if (reset) begin
            srca   <= '0;
            srcb   <= '0;
            cmd    <= '0;
            result <= '0;
        end else begin
            if (srca_lo_we) srca[WB_DATA_WIDTH-1:0]          <= dat_w;
            if (srca_hi_we) srca[DATA_WIDTH-1:WB_DATA_WIDTH] <= dat_w;
            if (srcb_lo_we) srcb[WB_DATA_WIDTH-1:0]          <= dat_w;
            if (srcb_hi_we) srcb[DATA_WIDTH-1:WB_DATA_WIDTH] <= dat_w;
            // Upper bits of the CMD word are ignored
            if (cmd_we)     cmd    <= vlu_cmd_t'(dat_w[CMD_WIDTH-1:0]);
            if (result_we)  result <= alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/vlu_control.sv ====
/*
 * Vector logic unit control
 * Wishbone classic slave FSM, register strobes, done flag and read mux
 */
`timescale 1ns/1ps
`default_nettype none

module vlu_control
    import vlu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  wb_addr_t    adr,
    input  wb_data_t    dat_w,
    output wb_data_t    dat_r,
    output logic        ack,
    output logic        srca_lo_we,
    output logic        srca_hi_we,
    output logic        srcb_lo_we,
    output logic        srcb_hi_we,
    output logic        cmd_we,
    output logic        result_we,
    input  vlu_result_t result
);
    vlu_ctrl_state_e state;
    vlu_ctrl_state_e state_next;
    logic            accept;
    logic            wr_accept;
    logic            done;
    wb_data_t        rd_data;
    vlu_cmd_t        wr_cmd;

    assign accept    = (state == ST_IDLE) && cyc && stb;
    assign wr_accept = accept && we;

    assign srca_lo_we = wr_accept && (adr == ADDR_SRCA_LO);
    assign srca_hi_we = wr_accept && (adr == ADDR_SRCA_HI);
    assign srcb_lo_we = wr_accept && (adr == ADDR_SRCB_LO);
    assign srcb_hi_we = wr_accept && (adr == ADDR_SRCB_HI);
    assign cmd_we     = wr_accept && (adr == ADDR_CMD);
    // ALU settles on the registered command during EXEC
    assign result_we  = (state == ST_EXEC);
    assign ack        = (state == ST_ACK);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (accept) state_next = cmd_we ? ST_EXEC : ST_ACK;
            ST_EXEC: state_next = ST_ACK;
            ST_ACK:  state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (cmd_we) begin
            done <= 1'b0;
        end else if (result_we) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        rd_data = '0;
        case (adr)
            ADDR_STATUS:    rd_data[0] = done;
            ADDR_RESULT_LO: rd_data = result.data[WB_DATA_WIDTH-1:0];
            ADDR_RESULT_HI: rd_data = result.data[DATA_WIDTH-1:WB_DATA_WIDTH];
            ADDR_VALID:     rd_data[NUM_BYTES-1:0] = result.valid;
            default:        rd_data = '0;
        endcase
    end

    // Read data lands together with ack
    always_ff @(posedge clk) begin
        if (reset) begin
            dat_r <= '0;
        end else if (accept && !we) begin
            dat_r <= rd_data;
        end
    end

    assign wr_cmd = dat_w[CMD_WIDTH-1:0];

    a_ack_with_stb: assert property (@(posedge clk) disable iff (reset) ack |-> stb);

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({srca_lo_we, srca_hi_we, srcb_lo_we, srcb_hi_we, cmd_we, result_we}));

    // Tail clearing in the ALU relies on vl staying in range
    a_cmd_vl_range: assert property (@(posedge clk) disable iff (reset)
        cmd_we |-> (wr_cmd.vl <= DATA_WIDTH));

endmodule

`default_nettype wire

// ==== logic/vlu_top.sv ====
/*
 * Vector logic unit top
 * Wishbone coprocessor around the vector logical ALU
 */
`timescale 1ns/1ps
`default_nettype none

module vlu_top
    import vlu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     cyc,
    input  logic     stb,
    input  logic     we,
    input  wb_addr_t adr,
    input  wb_data_t dat_w,
    output wb_data_t dat_r,
    output logic     ack
);
    logic        srca_lo_we;
    logic        srca_hi_we;
    logic        srcb_lo_we;
    logic        srcb_hi_we;
    logic        cmd_we;
    logic        result_we;
    vlu_data_t   srca;
    vlu_data_t   srcb;
    vlu_cmd_t    cmd;
    vlu_result_t alu_result;
    vlu_result_t result;

    vlu_control control (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .srca_lo_we (srca_lo_we),
        .srca_hi_we (srca_hi_we),
        .srcb_lo_we (srcb_lo_we),
        .srcb_hi_we (srcb_hi_we),
        .cmd_we     (cmd_we),
        .result_we  (result_we),
        .result     (result)
    );

    vlu_operand_regs regs (
        .clk        (clk),
        .reset      (reset),
        .dat_w      (dat_w),
        .srca_lo_we (srca_lo_we),
        .srca_hi_we (srca_hi_we),
        .srcb_lo_we (srcb_lo_we),
        .srcb_hi_we (srcb_hi_we),
        .cmd_we     (cmd_we),
        .result_we  (result_we),
        .alu_result (alu_result),
        .srca       (srca),
        .srcb       (srcb),
        .cmd        (cmd),
        .result     (result)
    );

    vector_logic_alu alu (
        .srca   (srca),
        .srcb   (srcb),
        .cmd    (cmd),
        .result (alu_result)
    );

endmodule

`default_nettype wire

// ==== testbench/vlu_tb.sv ====
/*
 * Vector logic unit testbench
 * Random Wishbone traffic from a fixed seed, checked against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module vlu_tb
    import vlu_pkg::*;
;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_BITWISE    = 40;
    localparam int N_SHIFT      = 40;
    localparam int N_MASK       = 20;
    localparam int N_REDUCT     = 30;
    localparam int N_HOLD       = 10;
    // Reset reads, 9 transfers per command, 17 per hold pass
    localparam int NUM_TRANS    = 4 + 9 * (N_BITWISE + N_SHIFT + N_MASK + N_REDUCT)
                                + 17 * N_HOLD;
    localparam int WATCHDOG_CYCLES = NUM_TRANS * 10 + RESET_CYCLES;

    logic     clk;
    logic     reset;
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;
    integer   seed;

    vlu_top UUT (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, a bus transfer never received its ack");
        $display("** FAIL **");
        $fatal(1, "watchdog timeout");
    end

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic check_data(input string name, input vlu_data_t exp, input vlu_data_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            abort_run("data mismatch");
        end
    endtask

    task automatic check_valid(input string name, input vlu_byte_valid_t exp,
                               input vlu_byte_valid_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            abort_run("valid mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            abort_run("status mismatch");
        end
    endtask

    // One classic cycle; ack is sampled on the falling edge
    task automatic bus_transfer(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                                output wb_data_t rdata);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        @(negedge clk);
        while (ack !== 1'b1) begin
            @(negedge clk);
        end
        rdata = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t wdata);
        wb_data_t unused;
        bus_transfer(1'b1, addr, wdata, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t rdata);
        bus_transfer(1'b0, addr, '0, rdata);
    endtask

    task automatic rand_data(output vlu_data_t d);
        d[31:0]  = $random(seed);
        d[63:32] = $random(seed);
    endtask

    task automatic rand_cmd(input logic shift_ops, output vlu_cmd_t c);
        logic [31:0] w1;
        logic [31:0] w2;
        w1 = $random(seed);
        w2 = $random(seed);
        c = '0;
        if (shift_ops) begin
            c.op = vlu_op_e'(3'(32'd3 + w1[7:0] % 32'd3));
        end else begin
            c.op = vlu_op_e'(3'(w1[7:0] % 32'd3));
        end
        c.osize         = vlu_osize_e'(w1[9:8]);
        c.negate_srca   = w1[10];
        c.negate_result = w1[11];
        c.is_mask       = w1[12];
        c.is_reduct     = w1[13];
        // Short lengths half the time so tails get cleared
        if (w2[31]) begin
            c.vl = vlu_vl_t'(w2[15:0] % 32'd9);
        end else begin
            c.vl = vlu_vl_t'(w2[15:0] % 32'd65);
        end
    endtask

    function automatic vlu_result_t model_result(input vlu_data_t a, input vlu_data_t b,
                                                 input vlu_cmd_t c);
        vlu_result_t r;
        logic        shift_op;
        int          ebits;
        int          ebytes;
        int          nelem;
        int          amt;
        vlu_data_t   emask;
        vlu_data_t   an;
        vlu_data_t   bw;
        vlu_data_t   ea;
        vlu_data_t   er;
        vlu_data_t   acc;
        shift_op = (c.op == OP_SLL) || (c.op == OP_SRL) || (c.op == OP_SRA);
        ebits    = (c.is_mask && shift_op) ? 8 : (8 << c.osize);
        ebytes   = ebits / 8;
        nelem    = DATA_WIDTH / ebits;
        emask    = (ebits == 64) ? '1 : ((64'd1 << ebits) - 64'd1);
        an       = c.negate_srca ? ~a : a;
        case (c.op)
            OP_AND:  bw = an & b;
            OP_OR:   bw = an | b;
            default: bw = an ^ b;
        endcase
        if (c.negate_result) bw = ~bw;
        r = '0;
        if (shift_op) begin
            for (int e = 0; e < nelem; e++) begin
                ea  = (a >> (e * ebits)) & emask;
                amt = int'((b >> (e * ebits)) & vlu_data_t'(ebits - 1));
                case (c.op)
                    OP_SLL:  er = (ea << amt) & emask;
                    OP_SRL:  er = ea >> amt;
                    default: begin
                        er = ea >> amt;
                        if (ea[ebits-1]) er = er | (emask & ~(emask >> amt));
                    end
                endcase
                if (e < int'(c.vl)) begin
                    r.data |= er << (e * ebits);
                    for (int k = 0; k < ebytes; k++) r.valid[e*ebytes+k] = 1'b1;
                end
            end
        end else if (c.is_mask) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                r.data[i] = (i < int'(c.vl)) ? bw[i] : 1'b0;
            end
            r.valid = '1;
        end else if (c.is_reduct) begin
            acc = b & emask;
            for (int e = 0; e < nelem; e++) begin
                if (e < int'(c.vl)) begin
                    ea = (an >> (e * ebits)) & emask;
                    case (c.op)
                        OP_AND:  acc = acc & ea;
                        OP_OR:   acc = acc | ea;
                        default: acc = acc ^ ea;
                    endcase
                end
            end
            if (c.negate_result) acc = ~acc;
            if (c.vl != '0) begin
                r.data = acc & emask;
                for (int k = 0; k < ebytes; k++) r.valid[k] = 1'b1;
            end
        end else begin
            for (int e = 0; e < nelem; e++) begin
                if (e < int'(c.vl)) begin
                    r.data |= bw & (emask << (e * ebits));
                    for (int k = 0; k < ebytes; k++) r.valid[e*ebytes+k] = 1'b1;
                end
            end
        end
        return r;
    endfunction

    task automatic load_operands(input vlu_data_t a, input vlu_data_t b);
        wb_write(ADDR_SRCA_LO, a[31:0]);
        wb_write(ADDR_SRCA_HI, a[63:32]);
        wb_write(ADDR_SRCB_LO, b[31:0]);
        wb_write(ADDR_SRCB_HI, b[63:32]);
    endtask

    task automatic read_and_compare(input string name, input vlu_result_t exp);
        wb_data_t lo;
        wb_data_t hi;
        wb_data_t vld;
        wb_read(ADDR_RESULT_LO, lo);
        wb_read(ADDR_RESULT_HI, hi);
        wb_read(ADDR_VALID, vld);
        check_data({name, " data"}, exp.data, {hi, lo});
        check_valid({name, " valid"}, exp.valid, vld[NUM_BYTES-1:0]);
    endtask

    task automatic run_and_check(input string name, input vlu_data_t a, input vlu_data_t b,
                                 input vlu_cmd_t c, output vlu_result_t exp);
        wb_data_t cmd_word;
        wb_data_t status;
        load_operands(a, b);
        cmd_word = '0;
        cmd_word[CMD_WIDTH-1:0] = c;
        wb_write(ADDR_CMD, cmd_word);
        exp = model_result(a, b, c);
        wb_read(ADDR_STATUS, status);
        check_status({name, " done"}, 1'b1, status[0]);
        read_and_compare(name, exp);
    endtask

    initial begin
        vlu_data_t   a;
        vlu_data_t   b;
        vlu_cmd_t    c;
        vlu_result_t exp;
        wb_data_t    rd;
        seed  = 32'h4d41_ca23;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        wb_read(ADDR_STATUS, rd);
        check_status("reset status", 1'b0, rd[0]);
        exp = '0;
        read_and_compare("reset result", exp);

        for (int i = 0; i < N_BITWISE; i++) begin
            rand_data(a);
            rand_data(b);
            rand_cmd(1'b0, c);
            c.is_mask   = 1'b0;
            c.is_reduct = 1'b0;
            run_and_check($sformatf("bitwise %0d", i), a, b, c, exp);
        end

        // All four sizes in turn, mask mode now and then
        for (int i = 0; i < N_SHIFT; i++) begin
            rand_data(a);
            rand_data(b);
            rand_cmd(1'b1, c);
            c.osize   = vlu_osize_e'(2'(i % 4));
            c.is_mask = (i % 8 == 7);
            run_and_check($sformatf("shift %0d", i), a, b, c, exp);
        end

        for (int i = 0; i < N_MASK; i++) begin
            rand_data(a);
            rand_data(b);
            rand_cmd(1'b0, c);
            c.is_mask = 1'b1;
            run_and_check($sformatf("mask %0d", i), a, b, c, exp);
        end

        for (int i = 0; i < N_REDUCT; i++) begin
            rand_data(a);
            rand_data(b);
            rand_cmd(1'b0, c);
            c.is_mask   = 1'b0;
            c.is_reduct = 1'b1;
            if (i % 6 == 0) c.vl = '0;
            run_and_check($sformatf("reduct %0d", i), a, b, c, exp);
        end

        // New operands must not disturb the captured result
        for (int i = 0; i < N_HOLD; i++) begin
            rand_data(a);
            rand_data(b);
            rand_cmd(i[0], c);
            run_and_check($sformatf("hold cmd %0d", i), a, b, c, exp);
            rand_data(a);
            rand_data(b);
            load_operands(a, b);
            wb_read(ADDR_STATUS, rd);
            check_status($sformatf("hold status %0d", i), 1'b1, rd[0]);
            read_and_compare($sformatf("hold result %0d", i), exp);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/vlu_pkg.sv
vector_alu/vector_shifter.sv
vector_alu/vector_reducer.sv
vector_alu/vector_logic_alu.sv
logic/vlu_operand_regs.sv
logic/vlu_control.sv
logic/vlu_top.sv
testbench/vlu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector logic unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module vlu_tb -o vlu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/vlu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
